// ==== arbiter/row_rr_arbiter.sv ====
// Round-robin row arbiter: masked and raw lowest-index priority, registered rotation mask
`timescale 1ns/1ps

module row_rr_arbiter #(
    parameter int ROWS  = 8,
    parameter int IDX_W = 3
) (
    input  logic             clk_i,
    input  logic             reset_i,   // Async, active high
    input  logic             enable_i,  // Move past the current grant
    input  logic [ROWS-1:0]  req_i,     // One bit per row
    output logic [ROWS-1:0]  gnt_o,     // One-hot, zero when no request
    output logic [IDX_W-1:0] idx_o      // Encoded grant
);

    logic [ROWS-1:0] mask_q;            // Rows still eligible in this round
    logic [ROWS-1:0] mask_nxt;          // Rows above the current grant
    logic [ROWS-1:0] mask_req;
    logic [ROWS-1:0] mask_gnt;
    logic [ROWS-1:0] raw_gnt;
    logic            wrap;              // Round used up, start a new group

    // Lowest set bit wins, isolated with the two's complement trick
    function automatic logic [ROWS-1:0] lowest_req(input logic [ROWS-1:0] req);
        return req & (~req + ROWS'(1));
    endfunction

    assign mask_req = req_i & mask_q;
    assign mask_gnt = lowest_req(mask_req);
    assign raw_gnt  = lowest_req(req_i);
    assign wrap     = ~|mask_req;

    // Fall back to the raw requests once nothing above the last grant is pending
    assign gnt_o = wrap ? raw_gnt : mask_gnt;

    // Next mask keeps only the rows above the grant
    always_comb
    begin
        mask_nxt = mask_q;
        for (int i = 0; i < ROWS; i++)
        begin
            if (gnt_o[i])
            begin
                mask_nxt = {ROWS{1'b1}} << (i + 1);  // Top row gives an empty mask
            end
        end
    end

    // One-hot to binary
    always_comb
    begin
        idx_o = '0;
        for (int i = 0; i < ROWS; i++)
        begin
            if (gnt_o[i])
            begin
                idx_o = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_q <= {ROWS{1'b1}};     // Every row eligible
        end
        else if (enable_i)
        begin
            mask_q <= mask_nxt;         // Rotate past the row just finished
        end
        else if (wrap)
        begin
            mask_q <= {ROWS{1'b1}};     // Idle wrap, reopen all rows
        end
    end

endmodule

// ==== bench/pixel_readout_props.sv ====
// Bound assertions: readout word hold under stall, arbiter grant shape, valid low in reset
`timescale 1ns/1ps
`include "pixel_macros.svh"

module pixel_readout_props (
    input logic                 clk_i,
    input logic                 reset_i,
    input pixel_pkg::ro_word_u  word_i,
    input logic                 word_valid_i,
    input logic                 word_ready_i,
    input logic [`PIX_ROWS-1:0] row_req_i,
    input logic [`PIX_ROWS-1:0] row_gnt_i
);

    int assert_errs = 0;                // Failed assertions so far, read by the testbench

    // Stalled word stays valid and unchanged until taken
    a_word_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (word_valid_i && !word_ready_i) |=> (word_valid_i && $stable(word_i)))
        else
        begin
            assert_errs++;
            $error("Readout word changed or dropped under back-pressure");
        end

    // At most one row granted
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(row_gnt_i))
        else
        begin
            assert_errs++;
            $error("Row grant is not one-hot");
        end

    // Grant only to a requesting row
    a_gnt_subset: assert property (@(posedge clk_i) disable iff (reset_i)
        (row_gnt_i & ~row_req_i) == '0)
        else
        begin
            assert_errs++;
            $error("Row grant without a row request");
        end

    a_reset_valid: assert property (@(posedge clk_i) reset_i |-> !word_valid_i)
        else
        begin
            assert_errs++;
            $error("Word valid high during reset");
        end

endmodule

bind pixel_readout_top pixel_readout_props i_pixel_readout_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .word_i       (word_o),
    .word_valid_i (word_valid_o),
    .word_ready_i (word_ready_i),
    .row_req_i    (row_req),
    .row_gnt_i    (row_gnt)
);

// ==== bench/pixel_readout_tb.sv ====
// Trace-driven testbench for the pixel readout block, with a round-robin reference model
`timescale 1ns/1ps
`include "pixel_macros.svh"

module pixel_readout_tb;

    localparam int NPIX      = `PIX_ROWS * `PIX_COLS;
    localparam int WORD_TOUT = 400;     // Cycles allowed between two transfers
    localparam int IDLE_TOUT = 50;      // Cycles allowed for busy to drop before a test

    logic                    clk = 1'b0;
    logic                    reset;
    logic [NPIX-1:0]         hit;
    logic                    word_ready;
    pixel_pkg::ro_word_u     word;
    logic                    word_valid;
    logic                    busy;

    logic [`PIX_ROWS-1:0]    rr_mask;   // Model arbiter mask, rows above the last one served
    logic [`PIX_TAG_W-1:0]   ref_tag;   // Model readout tag
    pixel_pkg::hit_word_t    exp_hits[$];
    pixel_pkg::marker_word_t exp_marker;
    int                      checks;
    int                      value_errs;
    int                      other_errs;
    bit                      aborted;   // Set on a timeout, skips the remaining records

    pixel_readout_top i_pixel_readout_top (
        .clk_i        (clk),
        .reset_i      (reset),
        .hit_i        (hit),
        .word_ready_i (word_ready),
        .word_o       (word),
        .word_valid_o (word_valid),
        .busy_o       (busy)
    );

    always #20 clk = ~clk;              // 40 ns period

    task automatic check_hit_word(input string name, input pixel_pkg::hit_word_t exp_w,
                                  input pixel_pkg::hit_word_t act_w);
        checks++;
        if (act_w !== exp_w)
        begin
            value_errs++;
            $display("FAILED %s: hit word expected %h, actual %h", name, exp_w, act_w);
        end
    endtask

    task automatic check_marker_word(input string name, input pixel_pkg::marker_word_t exp_w,
                                     input pixel_pkg::marker_word_t act_w);
        checks++;
        if (act_w !== exp_w)
        begin
            value_errs++;
            $display("FAILED %s: marker expected %h, actual %h", name, exp_w, act_w);
        end
    endtask

    // Expected words: rows in round-robin order after the last row served, columns ascending
    function automatic void build_expected(input logic [NPIX-1:0] mask);
        logic [`PIX_ROWS-1:0] rows;
        logic [`PIX_ROWS-1:0] masked;
        pixel_pkg::hit_word_t w;
        int                   r;
        int                   cnt;
        exp_hits.delete();
        cnt = 0;
        for (int i = 0; i < `PIX_ROWS; i++)
            rows[i] = |mask[i*`PIX_COLS +: `PIX_COLS];
        while (rows != '0)
        begin
            masked = rows & rr_mask;
            if (masked == '0)
                masked = rows;          // Wrap, every row eligible again
            r = 0;
            while (!masked[r])
                r++;
            for (int c = 0; c < `PIX_COLS; c++)
            begin
                if (mask[r*`PIX_COLS + c])
                begin
                    w.kind     = 1'b0;
                    w.addr.row = `PIX_ROW_W'(r);
                    w.addr.col = `PIX_COL_W'(c);
                    w.tag      = ref_tag;
                    exp_hits.push_back(w);
                    cnt++;
                end
            end
            rows[r] = 1'b0;
            rr_mask = {`PIX_ROWS{1'b1}} << (r + 1);     // Resume above this row
        end
        rr_mask          = '1;          // Drained and idle, arbiter reopens all rows
        exp_marker.kind  = 1'b1;
        exp_marker.tag   = ref_tag[`PIX_TAG_W-2:0];
        exp_marker.count = `PIX_CNT_W'(cnt);
    endfunction

    // One readout: pulse the hits, collect words under random stalls, then check idle
    task automatic run_test(input string name, input logic [NPIX-1:0] mask, input int stall);
        int                   wait_cnt;
        bit                   got_marker;
        bit                   held;
        pixel_pkg::ro_word_u  held_word;
        pixel_pkg::ro_word_u  act;
        wait_cnt = 0;
        while (busy && wait_cnt < IDLE_TOUT)
        begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        if (busy)
        begin
            other_errs++;
            $display("ERROR: %s block still busy before the hits were applied", name);
            aborted = 1'b1;
            return;
        end
        build_expected(mask);
        hit = mask;                     // One-cycle pulse
        @(posedge clk);
        #2;
        hit        = '0;
        got_marker = 1'b0;
        held       = 1'b0;
        wait_cnt   = 0;
        while (!got_marker && wait_cnt < WORD_TOUT)
        begin
            word_ready = (($urandom % 100) >= stall);
            @(negedge clk);             // Everything settled here
            act = word;
            if (!busy)                  // Readout runs until the marker is taken
            begin
                other_errs++;
                $display("ERROR: %s busy low while the readout is still running", name);
            end
            if (held && (!word_valid || act !== held_word))
            begin
                other_errs++;
                $display("ERROR: %s word changed or dropped while ready was low", name);
            end
            held      = word_valid && !word_ready;
            held_word = act;
            if (word_valid && word_ready)
            begin
                wait_cnt = 0;
                if (act.hit.kind == 1'b0)
                begin
                    if (exp_hits.size() == 0)
                    begin
                        other_errs++;
                        $display("ERROR: %s got more hit words than pixels were hit", name);
                    end
                    else
                        check_hit_word(name, exp_hits.pop_front(), act.hit);
                end
                else
                begin
                    if (exp_hits.size() != 0)
                    begin
                        other_errs++;
                        $display("ERROR: %s marker came with %0d hit words missing", name,
                                 exp_hits.size());
                    end
                    check_marker_word(name, exp_marker, act.marker);
                    got_marker = 1'b1;
                end
            end
            else
                wait_cnt++;
            @(posedge clk);
            #2;
        end
        if (!got_marker)
        begin
            other_errs++;
            $display("ERROR: %s timed out waiting for the next readout word", name);
            aborted = 1'b1;
            return;
        end
        if (busy)                       // One edge after the marker transfer
        begin
            other_errs++;
            $display("ERROR: %s busy still high after the marker was accepted", name);
        end
        ref_tag++;
    endtask

    initial
    begin
        int              fd;
        int              n_tests;
        int              stall;
        int              assert_errs;
        string           line;
        string           name;
        logic [NPIX-1:0] mask;
        void'($urandom(32'h54eb_a263));  // Stall generator seeded once
        reset      = 1'b1;
        hit        = '0;
        word_ready = 1'b0;
        checks     = 0;
        value_errs = 0;
        other_errs = 0;
        aborted    = 1'b0;
        rr_mask    = '1;
        ref_tag    = '0;
        n_tests    = 0;
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            #2;
            if (word_valid || busy)
            begin
                other_errs++;
                $display("ERROR: word valid or busy high during reset");
            end
        end
        reset = 1'b0;
        fd = $fopen("bench/readout_trace.txt", "r");
        if (fd == 0)
        begin
            other_errs++;
            $display("ERROR: could not open bench/readout_trace.txt");
        end
        else
        begin
            while (!aborted && $fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    if ($sscanf(line, "%s %h %d", name, mask, stall) == 3)
                    begin
                        run_test(name, mask, stall);
                        n_tests++;
                    end
                    else
                    begin
                        other_errs++;
                        $display("ERROR: trace line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
            if (n_tests == 0)
            begin
                other_errs++;
                $display("ERROR: no test records found in the trace file");
            end
        end
        // Failures of the bound assertions
        assert_errs = i_pixel_readout_top.i_pixel_readout_props.assert_errs;
        $display("Tests %0d, checks %0d, value mismatches %0d, other errors %0d, %s %0d",
                 n_tests, checks, value_errs, other_errs, "assertion failures", assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== bench/readout_trace.txt ====
# Columns: test name, hit mask (128-bit hex, bit row*16+col, row 7 leftmost),
# ready stall probability in percent (0 to 99)

# Single pixels at the middle and the two corners
single_hit          00000000000000000020000000000000 0
single_top          80000000000000000000000000000000 10
single_corner       00000000000000000000000000000001 50

# One full row, then scattered hits in several rows
full_row            00000000ffff00000000000000000000 0
scattered           80010000010000000000123400008000 0

# Consecutive readouts over different row sets
rr_pair             0000000300000000000000000c000000 0
rr_three            00010000000000100000000000004000 0
rr_pair_again       0000000300000000000000000c000000 5

# Random back-pressure on the readout bus
stall_light         00f00000aaaa0000010100000000f00f 25
stall_heavy         ffff000000000f0f0000000084210000 60

# Whole matrix, with and without stalls
full_matrix         ffffffffffffffffffffffffffffffff 0
full_matrix_stall   ffffffffffffffffffffffffffffffff 30

// ==== common/pixel_macros.svh ====
// Pixel block sizing: matrix dimensions, index widths, tag and hit count widths
`ifndef PIXEL_MACROS_SVH
`define PIXEL_MACROS_SVH

// Matrix dimensions
`define PIX_ROWS   8
`define PIX_COLS   16

// Pixel address fields, sized to the matrix
`define PIX_ROW_W  3
`define PIX_COL_W  4

// Readout tag carried in every hit word
`define PIX_TAG_W  8

// Hit count in the end-of-readout marker
// Must hold PIX_ROWS*PIX_COLS
`define PIX_CNT_W  8

`endif

// ==== common/pixel_pkg.sv ====
// Readout types: pixel address, hit word and marker word layouts, output word union
`include "pixel_macros.svh"

package pixel_pkg;

    // One pixel position in the matrix, 7 bits
    typedef struct packed {
        logic [`PIX_ROW_W-1:0] row;     // Row index
        logic [`PIX_COL_W-1:0] col;     // Column index
    } pix_addr_t;

    // Hit word, kind bit is 0
    typedef struct packed {
        logic                  kind;    // Always 0 here
        pix_addr_t             addr;    // Pixel that fired
        logic [`PIX_TAG_W-1:0] tag;     // Readout this hit belongs to
    } hit_word_t;

    // End-of-readout marker, kind bit is 1
    // Only the low tag bits fit next to the count
    typedef struct packed {
        logic                  kind;    // Always 1 here
        logic [`PIX_TAG_W-2:0] tag;     // Low 7 tag bits
        logic [`PIX_CNT_W-1:0] count;   // Hits read in this readout
    } marker_word_t;

    // Output bus word, 16 bits
    // The kind bit is the MSB in both views so a consumer can
    // look at it first and pick the matching layout
    typedef union packed {
        hit_word_t    hit;
        marker_word_t marker;
    } ro_word_u;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pixel readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=pixel_readout_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module "$TOP" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V$TOP +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $? -ne 0 ]; then
    echo "Could not show $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
exit 0

// ==== src/pixel_hit_matrix.sv ====
// Pixel hit matrix: per-pixel latches, row requests, lowest pending column of the granted row
`timescale 1ns/1ps
`include "pixel_macros.svh"

module pixel_hit_matrix (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [`PIX_ROWS*`PIX_COLS-1:0] hit_i,       // Row-major, bit r*COLS+c
    input  logic [`PIX_ROWS-1:0]           row_gnt_i,   // One-hot from the arbiter
    input  logic                           rd_i,        // Clear the addressed latch
    input  pixel_pkg::pix_addr_t           rd_addr_i,
    output logic [`PIX_ROWS-1:0]           row_req_o,   // OR of each row's latches
    output logic                           col_valid_o, // Granted row has a pending pixel
    output logic [`PIX_COL_W-1:0]          col_idx_o,   // Lowest pending column there
    output logic                           row_last_o   // That column is the last in the row
);

    logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] hit_2d;
    logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pend_q;
    logic [`PIX_ROWS-1:0][`PIX_COLS-1:0] pend_d;
    logic [`PIX_COLS-1:0]                row_bits;      // Pending bits of the granted row

    assign hit_2d = hit_i;

    // Read clears first, a new hit on the same edge sets it again
    always_comb
    begin
        pend_d = pend_q;
        if (rd_i)
        begin
            pend_d[rd_addr_i.row][rd_addr_i.col] = 1'b0;
        end
        pend_d = pend_d | hit_2d;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            pend_q <= '0;
        else
            pend_q <= pend_d;
    end

    always_comb
    begin
        row_bits = '0;
        for (int r = 0; r < `PIX_ROWS; r++)
        begin
            row_req_o[r] = |pend_q[r];
            if (row_gnt_i[r])
                row_bits = row_bits | pend_q[r];    // One-hot mux as an AND-OR
        end
    end

    // Priority encode, scanning down so the lowest column is assigned last
    always_comb
    begin
        col_idx_o = '0;
        for (int c = `PIX_COLS - 1; c >= 0; c--)
        begin
            if (row_bits[c])
                col_idx_o = `PIX_COL_W'(c);
        end
    end

    assign col_valid_o = |row_bits;
    // Clearing the lowest set bit leaves nothing, so it is the only one
    assign row_last_o  = col_valid_o & ~|(row_bits & (row_bits - 1'b1));

endmodule

// ==== src/pixel_readout_top.sv ====
// Pixel block readout top: hit matrix, round-robin row arbiter and readout sequencer
`timescale 1ns/1ps
`include "pixel_macros.svh"

module pixel_readout_top (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [`PIX_ROWS*`PIX_COLS-1:0] hit_i,
    input  logic                           word_ready_i,
    output pixel_pkg::ro_word_u            word_o,
    output logic                           word_valid_o,
    output logic                           busy_o
);

    logic [`PIX_ROWS-1:0]  row_req;     // Matrix to arbiter
    logic [`PIX_ROWS-1:0]  row_gnt;     // Arbiter to matrix
    logic [`PIX_ROW_W-1:0] row_idx;     // Arbiter to sequencer
    logic                  col_valid;
    logic [`PIX_COL_W-1:0] col_idx;
    logic                  row_last;
    logic                  rd;          // Sequencer clears one latch
    pixel_pkg::pix_addr_t  rd_addr;
    logic                  advance;     // Sequencer rotates the arbiter

    pixel_hit_matrix i_pixel_hit_matrix (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .hit_i       (hit_i),
        .row_gnt_i   (row_gnt),
        .rd_i        (rd),
        .rd_addr_i   (rd_addr),
        .row_req_o   (row_req),
        .col_valid_o (col_valid),
        .col_idx_o   (col_idx),
        .row_last_o  (row_last)
    );

    row_rr_arbiter #(
        .ROWS  (`PIX_ROWS),
        .IDX_W (`PIX_ROW_W)
    ) i_row_rr_arbiter (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .enable_i (advance),
        .req_i    (row_req),
        .gnt_o    (row_gnt),
        .idx_o    (row_idx)
    );

    readout_sequencer i_readout_sequencer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .row_idx_i    (row_idx),
        .col_valid_i  (col_valid),
        .col_idx_i    (col_idx),
        .row_last_i   (row_last),
        .word_ready_i (word_ready_i),
        .rd_o         (rd),
        .rd_addr_o    (rd_addr),
        .advance_o    (advance),
        .word_o       (word_o),
        .word_valid_o (word_valid_o),
        .busy_o       (busy_o)
    );

endmodule

// ==== src/readout_sequencer.sv ====
// Readout sequencer: hit and marker word build, output register with valid/ready, hit count and tag
`timescale 1ns/1ps
`include "pixel_macros.svh"

module readout_sequencer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic [`PIX_ROW_W-1:0] row_idx_i,    // Granted row
    input  logic                  col_valid_i,  // Any pixel pending in that row
    input  logic [`PIX_COL_W-1:0] col_idx_i,
    input  logic                  row_last_i,
    input  logic                  word_ready_i,
    output logic                  rd_o,         // Clear strobe to the matrix
    output pixel_pkg::pix_addr_t  rd_addr_o,
    output logic                  advance_o,    // Row done, rotate the arbiter
    output pixel_pkg::ro_word_u   word_o,
    output logic                  word_valid_o,
    output logic                  busy_o
);

    pixel_pkg::pix_addr_t     hit_addr;
    pixel_pkg::ro_word_u      nxt_word;
    pixel_pkg::ro_word_u      word_q;           // Output register payload
    logic                     valid_q;
    logic [`PIX_TAG_W-1:0]    tag_q;            // Current readout tag
    logic [`PIX_CNT_W-1:0]    cnt_q;            // Hits loaded in this readout
    logic                     load_en;
    logic                     hit_load;
    logic                     mark_load;
    logic                     cnt_nz;

    // Register free now, or emptied by a transfer on this edge
    assign load_en   = ~valid_q | word_ready_i;
    assign cnt_nz    = |cnt_q;

    // Hits take priority, marker once the matrix is drained
    assign hit_load  = load_en & col_valid_i;
    assign mark_load = load_en & ~col_valid_i & cnt_nz;

    assign hit_addr.row = row_idx_i;
    assign hit_addr.col = col_idx_i;

    assign rd_o      = hit_load;                // Latch clears on the loading edge
    assign rd_addr_o = hit_addr;
    assign advance_o = hit_load & row_last_i;   // Last pixel of the row leaves

    // Word to load, decoded as hit or marker by the kind bit
    always_comb
    begin
        nxt_word = '0;
        if (col_valid_i)
        begin
            nxt_word.hit.kind = 1'b0;
            nxt_word.hit.addr = hit_addr;
            nxt_word.hit.tag  = tag_q;
        end
        else
        begin
            nxt_word.marker.kind  = 1'b1;
            nxt_word.marker.tag   = tag_q[`PIX_TAG_W-2:0];   // Truncated tag
            nxt_word.marker.count = cnt_q;
        end
    end

    // Payload only moves on a load
    always_ff @(posedge clk_i)
    begin
        if (hit_load | mark_load)
            word_q <= nxt_word;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            valid_q <= 1'b0;
            tag_q   <= '0;
            cnt_q   <= '0;
        end
        else
        begin
            if (load_en)
                valid_q <= hit_load | mark_load;    // Drops when accepted with nothing new
            if (hit_load)
            begin
                cnt_q <= cnt_q + 1'b1;
            end
            else if (mark_load)
            begin
                cnt_q <= '0;                        // Next readout starts fresh
                tag_q <= tag_q + 1'b1;
            end
        end
    end

    assign word_o       = word_q;
    assign word_valid_o = valid_q;
    // Held word covers the gap between the last hit and the marker
    assign busy_o       = col_valid_i | valid_q;

endmodule

// ==== verilog.f ====
+incdir+common
common/pixel_pkg.sv
arbiter/row_rr_arbiter.sv
src/pixel_hit_matrix.sv
src/readout_sequencer.sv
src/pixel_readout_top.sv
bench/pixel_readout_props.sv
bench/pixel_readout_tb.sv
